// ==== rtl/accel_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_bus_regs (
	input  wire                           clk,
	input  wire                           rst_n,
	input  sha256_sched_pkg::bus_req_t    bus_req,
	output sha256_sched_pkg::bus_rsp_t    bus_rsp,
	output logic                          go,
	output sha256_sched_pkg::word_t       data_words [sha256_sched_pkg::blk_words],
	output sha256_sched_pkg::sched_idx_t  sched_rd_idx,
	input  sha256_sched_pkg::word_t       sched_rd_word,
	input  wire                           done
);

	localparam int slot_w = $clog2(sha256_sched_pkg::blk_words);

	sha256_sched_pkg::resp_e    resp_q;
	sha256_sched_pkg::word_t    rdata_q;
	sha256_sched_pkg::word_t    rd_word;
	sha256_sched_pkg::reg_idx_t idx;
	sha256_sched_pkg::reg_idx_t data_off;
	sha256_sched_pkg::reg_idx_t sched_off;
	logic [slot_w-1:0]          data_slot;
	logic                       accept;
	logic                       resp_en;
	logic                       ctrl_hit;
	logic                       data_hit;
	logic                       sched_hit;

	assign idx = bus_req.addr[sha256_sched_pkg::addr_w-1:2];
	assign accept = bus_req.req && (resp_q == sha256_sched_pkg::resp_not_ready);
	// the response toggles only when req and resp disagree.
	assign resp_en = (resp_q == sha256_sched_pkg::resp_ready_ok) ^ bus_req.req;

	assign data_off = idx - sha256_sched_pkg::data_base;
	assign sched_off = idx - sha256_sched_pkg::sched_base;
	assign data_slot = data_off[slot_w+1:2];

	assign ctrl_hit = (idx == sha256_sched_pkg::ctrl_idx);
	assign data_hit = (idx >= sha256_sched_pkg::data_base) &&
		(data_off < sha256_sched_pkg::reg_idx_t'(sha256_sched_pkg::blk_words));
	assign sched_hit = (idx >= sha256_sched_pkg::sched_base) &&
		(sched_off < sha256_sched_pkg::reg_idx_t'(sha256_sched_pkg::sched_words));
	assign sched_rd_idx = sha256_sched_pkg::sched_idx_t'(sched_off);

	always_comb begin
		rd_word = '0;
		if (ctrl_hit) begin
			rd_word[sha256_sched_pkg::done_bit] = done;
		end else if (data_hit) begin
			rd_word = data_words[data_slot];
		end else if (sched_hit) begin
			rd_word = sched_rd_word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_q <= sha256_sched_pkg::resp_not_ready;
		end else if (resp_en) begin
			resp_q <= bus_req.req ? sha256_sched_pkg::resp_ready_ok :
				sha256_sched_pkg::resp_not_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= rd_word; // sampled at acceptance and held through the response.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			go <= 1'b0;
		end else begin
			go <= accept && bus_req.wr && ctrl_hit &&
				bus_req.wdata[sha256_sched_pkg::go_bit];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sha256_sched_pkg::blk_words; i++) begin
				data_words[i] <= '0;
			end
		end else if (accept && bus_req.wr && data_hit) begin
			data_words[data_slot] <= bus_req.wdata;
		end
	end

	assign bus_rsp.resp = resp_q;
	assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/sched_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_store (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           go,
	input  sha256_sched_pkg::word_t       data_words [sha256_sched_pkg::blk_words],
	output sha256_sched_pkg::lane_taps_t  taps_a,
	output sha256_sched_pkg::lane_taps_t  taps_b,
	input  sha256_sched_pkg::word_t       word_a,
	input  sha256_sched_pkg::word_t       word_b,
	input  sha256_sched_pkg::sched_idx_t  rd_idx,
	output sha256_sched_pkg::word_t       rd_word,
	output logic                          done
);

	// one idle step after the last write before done is raised.
	localparam sha256_sched_pkg::step_t end_step = sha256_sched_pkg::last_step + 5'd1;

	sha256_sched_pkg::word_t      sched [sha256_sched_pkg::sched_words];
	sha256_sched_pkg::step_t      step;
	sha256_sched_pkg::sched_idx_t idx_a;
	sha256_sched_pkg::sched_idx_t idx_b;
	logic                         busy;

	function automatic sha256_sched_pkg::word_t byte_swap(input sha256_sched_pkg::word_t d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	// step s writes words 2s+14 and 2s+15.
	assign idx_a = {step, 1'b0} + sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::blk_words - 2);
	assign idx_b = idx_a + 6'd1;

	always_comb begin
		taps_a.w_m2  = sched[idx_a - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d2)];
		taps_a.w_m7  = sched[idx_a - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d7)];
		taps_a.w_m15 = sched[idx_a - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d15)];
		taps_a.w_m16 = sched[idx_a - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d16)];
		// each lane's two-back word is the one the same lane wrote on the previous step.
		taps_b.w_m2  = sched[idx_b - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d2)];
		taps_b.w_m7  = sched[idx_b - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d7)];
		taps_b.w_m15 = sched[idx_b - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d15)];
		taps_b.w_m16 = sched[idx_b - sha256_sched_pkg::sched_idx_t'(sha256_sched_pkg::tap_d16)];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sha256_sched_pkg::sched_words; i++) begin
				sched[i] <= '0;
			end
			step <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else if (go) begin
			// step 0 loads the block, and a go during a run starts over from here.
			for (int i = 0; i < sha256_sched_pkg::blk_words; i++) begin
				sched[i] <= byte_swap(data_words[i]);
			end
			step <= 5'd1;
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy) begin
			if (step == end_step) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				sched[idx_a] <= word_a;
				sched[idx_b] <= word_b;
				step <= step + 5'd1;
			end
		end
	end

	assign rd_word = sched[rd_idx];

endmodule

`default_nettype wire

// ==== rtl/sched_word_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_word_unit (
	input  sha256_sched_pkg::lane_taps_t taps,
	output sha256_sched_pkg::word_t      word
);

	sha256_sched_pkg::word_t sig0;
	sha256_sched_pkg::word_t sig1;

	function automatic sha256_sched_pkg::word_t rotr(
		input sha256_sched_pkg::word_t x,
		input int                      n
	);
		return (x >> n) | (x << (sha256_sched_pkg::word_w - n));
	endfunction

	// small sigma zero on the word fifteen back.
	assign sig0 = rotr(taps.w_m15, sha256_sched_pkg::s0_rot_a) ^
		rotr(taps.w_m15, sha256_sched_pkg::s0_rot_b) ^
		(taps.w_m15 >> sha256_sched_pkg::s0_shr);

	// small sigma one on the word two back.
	assign sig1 = rotr(taps.w_m2, sha256_sched_pkg::s1_rot_a) ^
		rotr(taps.w_m2, sha256_sched_pkg::s1_rot_b) ^
		(taps.w_m2 >> sha256_sched_pkg::s1_shr);

	assign word = sig1 + taps.w_m7 + sig0 + taps.w_m16; // wraps modulo 2^32.

endmodule

`default_nettype wire

// ==== rtl/sha256_sched_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_sched_accel (
	input  wire                        clk,
	input  wire                        rst_n,
	input  sha256_sched_pkg::bus_req_t bus_req,
	output sha256_sched_pkg::bus_rsp_t bus_rsp
);

	logic                         go;
	logic                         done;
	sha256_sched_pkg::word_t      data_words [sha256_sched_pkg::blk_words];
	sha256_sched_pkg::sched_idx_t sched_rd_idx;
	sha256_sched_pkg::word_t      sched_rd_word;
	sha256_sched_pkg::lane_taps_t taps_a;
	sha256_sched_pkg::lane_taps_t taps_b;
	sha256_sched_pkg::word_t      word_a;
	sha256_sched_pkg::word_t      word_b;

	accel_bus_regs u_regs (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus_req       (bus_req),
		.bus_rsp       (bus_rsp),
		.go            (go),
		.data_words    (data_words),
		.sched_rd_idx  (sched_rd_idx),
		.sched_rd_word (sched_rd_word),
		.done          (done)
	);

	sched_store u_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.go         (go),
		.data_words (data_words),
		.taps_a     (taps_a),
		.taps_b     (taps_b),
		.word_a     (word_a),
		.word_b     (word_b),
		.rd_idx     (sched_rd_idx),
		.rd_word    (sched_rd_word),
		.done       (done)
	);

	// even word of each step.
	sched_word_unit lane_a (
		.taps (taps_a),
		.word (word_a)
	);

	// odd word of each step.
	sched_word_unit lane_b (
		.taps (taps_b),
		.word (word_b)
	);

endmodule

`default_nettype wire

// ==== rtl/sha256_sched_pkg.sv ====
`default_nettype none

package sha256_sched_pkg;

	localparam int word_w = 32;
	typedef logic [word_w-1:0] word_t;

	localparam int addr_w = 9;
	typedef logic [addr_w-1:2] reg_idx_t; // word index, byte offset bits dropped.

	localparam int blk_words = 16;
	localparam int sched_words = 64;
	typedef logic [$clog2(sched_words)-1:0] sched_idx_t;

	localparam reg_idx_t ctrl_idx = 7'd0;
	localparam reg_idx_t data_base = 7'd1;
	localparam reg_idx_t sched_base = 7'd17;

	typedef logic [4:0] step_t;
	localparam step_t last_step = 5'd24; // two words per step, W16..W63.

	localparam int done_bit = 31;
	localparam int go_bit = 0;

	// message schedule recurrence distances and sigma constants.
	localparam int tap_d2 = 2;
	localparam int tap_d7 = 7;
	localparam int tap_d15 = 15;
	localparam int tap_d16 = 16;
	localparam int s0_rot_a = 7;
	localparam int s0_rot_b = 18;
	localparam int s0_shr = 3;
	localparam int s1_rot_a = 17;
	localparam int s1_rot_b = 19;
	localparam int s1_shr = 10;

	typedef enum logic [1:0] {
		resp_not_ready = 2'b00,
		resp_ready_ok  = 2'b01
	} resp_e;

	typedef struct packed {
		logic                req;
		logic                wr; // 1 for write.
		logic [addr_w-1:0]   addr;
		word_t               wdata;
	} bus_req_t;

	typedef struct packed {
		resp_e resp;
		word_t rdata;
	} bus_rsp_t;

	typedef struct packed {
		word_t w_m2;
		word_t w_m7;
		word_t w_m15;
		word_t w_m16;
	} lane_taps_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in sim.log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete, see build.log and sim.log"

cat sim.log 2> /dev/null
grep -q "Simulation finished: PASS" sim.log 2> /dev/null && exit 0 || exit 1

// ==== tb.f ====
rtl/sha256_sched_pkg.sv
rtl/sched_word_unit.sv
rtl/sched_store.sv
rtl/accel_bus_regs.sv
rtl/sha256_sched_accel.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== tests/sched_stim.txt ====
# one block per line: 16 data words as written on the bus, then expected W16..W63, all hex
# block 1 is the padded message "abc", block 2 is all zero
80636261 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 18000000 61626380 000f0000 7da86405 600003c6 3e9d7b78 0183fc00 12dcbfdb e2e2c38e c8215c1a b73679a2 e5bc3909 32663c5b 9d209d67 ec8726cb 702138a4 d3b7973b 93f5997f 3b68ba73 aff4ffc1 f10a5c62 0a8b3996 72af830a 9409e33e 24641522 9f47bf94 f0a64f5a 3e246a79 27333ba3 0c4763f2 840abf27 7a290d5d 065c43da fb3e89cb cc7617db b9e66c34 a9993667 84badedd c21462bc 1487472c b20f7a99 ef57b9cd ebe6b238 9fe3095e 78bc8d4b a43fcf15 668b2ff8 eeaba2cc 12b1edeb
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  wire                        clk,
	input  wire                        rst_n,
	input  sha256_sched_pkg::bus_req_t bus_req,
	input  sha256_sched_pkg::bus_rsp_t bus_rsp,
	output int                         errors
);

	localparam int max_blocks = 8;
	localparam int exp_words = 48;
	localparam int done_edges = 27; // first acceptance edge after go that sees done.

	sha256_sched_pkg::word_t mirror [16];
	sha256_sched_pkg::word_t snap [64];
	sha256_sched_pkg::word_t exp_hi [max_blocks * exp_words];
	sha256_sched_pkg::word_t pend_exp;
	int load_errors;
	int check_errors;
	int run_cnt;
	int go_cnt;
	logic pending;
	logic pend_wr;
	logic pend_known;
	logic release_seen;

	assign errors = load_errors + check_errors;

	function automatic sha256_sched_pkg::word_t reverse_bytes(input sha256_sched_pkg::word_t d);
		sha256_sched_pkg::word_t r;
		for (int b = 0; b < 4; b++) begin
			r[8*b +: 8] = d[8*(3-b) +: 8];
		end
		return r;
	endfunction

	initial begin
		int fd;
		int k;
		int blk;
		string tok;
		string rest;
		sha256_sched_pkg::word_t w;
		load_errors = 0;
		k = 0;
		blk = 0;
		fd = $fopen("tests/sched_stim.txt", "r");
		if (fd == 0) begin
			$display("checker could not open tests/sched_stim.txt");
			load_errors = 1;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.substr(0, 0) == "#") begin
					void'($fgets(rest, fd)); // skip the rest of a comment line.
				end else begin
					void'($sscanf(tok, "%h", w));
					if (k >= 16 && blk < max_blocks) begin
						exp_hi[blk*exp_words + k - 16] = w;
					end
					k++;
					if (k == 64) begin
						k = 0;
						blk++;
					end
				end
			end
			$fclose(fd);
		end
	end

	// expected read data at acceptance; pend_known is cleared while a run is under way.
	task automatic expect_read(input int idx);
		pend_known = 1'b1;
		pend_exp = '0;
		if (idx == int'(sha256_sched_pkg::ctrl_idx)) begin
			pend_exp[sha256_sched_pkg::done_bit] = (run_cnt >= done_edges);
		end else if (idx >= 1 && idx <= 16) begin
			pend_exp = mirror[idx-1];
		end else if (idx >= 17 && idx <= 80) begin
			if (run_cnt >= 0 && run_cnt < done_edges) begin
				pend_known = 1'b0;
			end else begin
				pend_exp = snap[idx-17];
			end
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		int idx;
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				mirror[i] = '0;
			end
			for (int i = 0; i < 64; i++) begin
				snap[i] = '0;
			end
			check_errors = 0;
			run_cnt = -1;
			go_cnt = 0;
			pending = 1'b0;
			pend_wr = 1'b0;
			pend_known = 1'b0;
			release_seen = 1'b0;
		end else begin
			if (run_cnt >= 0) begin
				run_cnt++;
			end
			if (release_seen && bus_rsp.resp != sha256_sched_pkg::resp_not_ready) begin
				$display("CHECK FAILED at %0t: resp still ready-ok after req was dropped", $time);
				check_errors++;
			end
			if (pending) begin
				if (bus_rsp.resp != sha256_sched_pkg::resp_ready_ok) begin
					$display("CHECK FAILED at %0t: no ready-ok one cycle after acceptance", $time);
					check_errors++;
				end else if (!pend_wr && pend_known && bus_rsp.rdata != pend_exp) begin
					$display("CHECK FAILED at %0t: read data %h, expected %h", $time,
						bus_rsp.rdata, pend_exp);
					check_errors++;
				end
				pending = 1'b0;
			end
			release_seen = (bus_rsp.resp == sha256_sched_pkg::resp_ready_ok) && !bus_req.req;
			if (bus_req.req && bus_rsp.resp == sha256_sched_pkg::resp_not_ready) begin
				idx = int'(bus_req.addr[sha256_sched_pkg::addr_w-1:2]);
				pending = 1'b1;
				pend_wr = bus_req.wr;
				expect_read(idx);
				if (bus_req.wr && idx >= 1 && idx <= 16) begin
					mirror[idx-1] = bus_req.wdata;
				end else if (bus_req.wr && idx == 0 && bus_req.wdata[sha256_sched_pkg::go_bit]) begin
					for (int i = 0; i < 16; i++) begin
						snap[i] = reverse_bytes(mirror[i]);
					end
					for (int i = 16; i < 64; i++) begin
						snap[i] = (go_cnt < max_blocks) ? exp_hi[go_cnt*exp_words + i - 16] : '0;
					end
					go_cnt++;
					run_cnt = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int resp_timeout = 20;
	localparam int done_polls = 100;
	localparam int unused_idx = 100;

	logic clk;
	logic rst_n;
	sha256_sched_pkg::bus_req_t bus_req;
	sha256_sched_pkg::bus_rsp_t bus_rsp;
	sha256_sched_pkg::word_t data [16];
	sha256_sched_pkg::word_t rd;
	int check_errors;
	int fail_count;
	int blocks;
	int fd;
	logic aborted;
	bit got_block;

	tb_clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	sha256_sched_accel DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	tb_checker u_checker (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.errors  (check_errors)
	);

	task automatic report_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		fail_count++;
		aborted = 1'b1;
	endtask

	// one full four-phase transaction, inputs change on falling edges only.
	task automatic bus_access(input logic wr, input int idx, input sha256_sched_pkg::word_t wdata,
		output sha256_sched_pkg::word_t rdata);
		int n;
		rdata = '0;
		if (aborted) return;
		@(negedge clk);
		bus_req.req = 1'b1;
		bus_req.wr = wr;
		bus_req.addr = {idx[6:0], 2'b00};
		bus_req.wdata = wdata;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (bus_rsp.resp != sha256_sched_pkg::resp_ready_ok && n < resp_timeout);
		if (bus_rsp.resp != sha256_sched_pkg::resp_ready_ok) begin
			report_timeout("resp ready-ok");
			return;
		end
		rdata = bus_rsp.rdata;
		bus_req.req = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (bus_rsp.resp != sha256_sched_pkg::resp_not_ready && n < resp_timeout);
		if (bus_rsp.resp != sha256_sched_pkg::resp_not_ready) begin
			report_timeout("resp not-ready");
		end
	endtask

	// 16 data words of one stim line; the expected words are the checker's business.
	task automatic read_block(output bit ok);
		int k;
		string tok;
		string rest;
		sha256_sched_pkg::word_t w;
		k = 0;
		ok = 1'b0;
		while (k < 64 && $fscanf(fd, "%s", tok) == 1) begin
			if (tok.substr(0, 0) == "#") begin
				void'($fgets(rest, fd));
			end else begin
				void'($sscanf(tok, "%h", w));
				if (k < 16) data[k] = w;
				k++;
			end
		end
		ok = (k == 64);
	endtask

	task automatic run_block();
		int polls;
		for (int i = 0; i < 16; i++) begin
			bus_access(1'b1, 1 + i, data[i], rd);
		end
		for (int i = 0; i < 16; i++) begin
			bus_access(1'b0, 1 + i, '0, rd);
		end
		bus_access(1'b1, 0, 32'h0000_0001, rd);
		polls = 0;
		rd = '0;
		while (!rd[sha256_sched_pkg::done_bit] && polls < done_polls && !aborted) begin
			bus_access(1'b0, 0, '0, rd);
			polls++;
		end
		if (!rd[sha256_sched_pkg::done_bit] && !aborted) begin
			report_timeout("done");
		end
		for (int i = 0; i < 64; i++) begin
			bus_access(1'b0, int'(sha256_sched_pkg::sched_base) + i, '0, rd);
		end
	endtask

	initial begin
		int n;
		bus_req = '0;
		fail_count = 0;
		blocks = 0;
		aborted = 1'b0;
		n = 0;
		while (rst_n !== 1'b1 && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1) report_timeout("reset release");
		fd = $fopen("tests/sched_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/sched_stim.txt");
			fail_count++;
			aborted = 1'b1;
		end
		bus_access(1'b0, 0, '0, rd); // control reads zero after reset.
		bus_access(1'b1, unused_idx, 32'hdead_beef, rd);
		bus_access(1'b0, unused_idx, '0, rd);
		got_block = 1'b1;
		while (!aborted && got_block) begin
			read_block(got_block);
			if (got_block) begin
				run_block();
				blocks++;
			end
		end
		if (blocks == 0) begin
			$display("no complete test block found in the stim file");
			fail_count++;
		end
		if (fd != 0) $fclose(fd);
		repeat (3) @(negedge clk);
		$display("blocks %0d, check errors %0d, other errors %0d", blocks, check_errors, fail_count);
		if (check_errors == 0 && fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
